// File: logic/fe_pkg.sv
`default_nettype none

package fe_pkg;

    // --------------------
    // widths and opcodes
    // --------------------

    // address and instruction width, rv32 without compressed support
    localparam int unsigned XLEN = 32;

    // major opcodes seen by the predecoder
    // conditional branches (beq, bne, blt, ...)
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    // jump and link with immediate target
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // --------------------
    // memory interface
    // --------------------

    // one request per cycle, no handshake
    typedef struct packed {
        logic            req;
        logic [XLEN-1:0] addr;
    } fetch_req_t;

    // answer arrives exactly one cycle after its request
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] data;
        // access error for this word
        logic            err;
    } fetch_rsp_t;

    // --------------------
    // internal payloads
    // --------------------

    // one queued instruction for the back end, 66 bits
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
        logic            pred_taken;
        logic            fault;
    } fetch_entry_t;

    // static prediction from the predecoder back to next-pc logic
    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } predict_t;

    // branch resolution from the back end
    typedef struct packed {
        logic            mispredict;
        logic [XLEN-1:0] target;
    } resolve_t;

    // csr redirects, exception entry and exception return
    typedef struct packed {
        logic            ex_valid;
        logic [XLEN-1:0] trap_vector;
        logic            eret;
        logic [XLEN-1:0] epc;
    } trap_t;

endpackage

`default_nettype wire

// File: logic/pc_gen.sv
`default_nettype none

module pc_gen (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    // held stable, sampled while the boot flag is set
    input  wire logic [fe_pkg::XLEN-1:0] boot_addr_i,
    // single-cycle redirect strobes from the back end
    input  wire fe_pkg::resolve_t        resolve_i,
    input  wire fe_pkg::trap_t           trap_i,
    // static prediction for the response of this cycle
    input  wire fe_pkg::predict_t        predict_i,
    // at least two free queue slots
    input  wire logic                    room_i,
    output fe_pkg::fetch_req_t           fetch_req_o,
    // address of the request issued in the previous cycle
    output logic [fe_pkg::XLEN-1:0]      req_addr_q_o,
    output logic                         drop_o,
    output logic                         flush_o
);
    import fe_pkg::*;

    logic [XLEN-1:0] npc_d;
    logic [XLEN-1:0] npc_q;
    // set in reset, loads boot_addr_i into the pc on the first edge
    logic            boot_q;
    logic            drop_q;
    logic            be_redirect;
    logic            redirect;
    logic            req;

    // --------------------
    // redirect detection
    // --------------------

    // back-end redirects also flush queue and predecoder
    assign be_redirect = trap_i.ex_valid | trap_i.eret | resolve_i.mispredict;
    // a taken prediction only kills the request in flight
    assign redirect    = be_redirect | predict_i.taken;

    // no request on the boot cycle or while the pc changes course
    assign req = room_i & ~boot_q & ~redirect;

    assign fetch_req_o.req  = req;
    assign fetch_req_o.addr = npc_q;

    assign flush_o = be_redirect;
    assign drop_o  = drop_q;

    // --------------------
    // next pc
    // --------------------

    // precedence: exception, eret, mispredict, prediction, boot, sequential
    always_comb begin : npc_select
        if (trap_i.ex_valid) begin
            npc_d = trap_i.trap_vector;
        end else if (trap_i.eret) begin
            npc_d = trap_i.epc;
        end else if (resolve_i.mispredict) begin
            npc_d = resolve_i.target;
        end else if (predict_i.taken) begin
            npc_d = predict_i.target;
        end else if (boot_q) begin
            npc_d = boot_addr_i;
        end else if (req) begin
            // uncompressed only, always step one word
            npc_d = npc_q + XLEN'(4);
        end else begin
            // stalled on a full queue, retry the same word
            npc_d = npc_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            npc_q  <= '0;
            boot_q <= 1'b1;
            drop_q <= 1'b0;
        end else begin
            npc_q  <= npc_d;
            // boot address is taken exactly once
            boot_q <= 1'b0;
            // kill whatever answer follows a redirect
            drop_q <= redirect;
        end
    end

    // remember the address so predecode can tag the answer
    always_ff @(posedge clk_i) begin
        if (req) begin
            req_addr_q_o <= npc_q;
        end
    end

    // --------------------
    // checks
    // --------------------

    // redirect targets from back end and predecoder must stay word aligned
    a_req_aligned : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        fetch_req_o.req |-> (fetch_req_o.addr[1:0] == 2'b00)
    ) else $error("fetch request to unaligned address %h", fetch_req_o.addr);

endmodule

`default_nettype wire

// File: logic/predecode.sv
`default_nettype none

module predecode (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    // answer to the request of the previous cycle
    input  wire fe_pkg::fetch_rsp_t      fetch_rsp_i,
    input  wire logic [fe_pkg::XLEN-1:0] req_addr_i,
    // answer belongs to a killed request
    input  wire logic                    drop_i,
    // back-end redirect in this cycle
    input  wire logic                    flush_i,
    output fe_pkg::fetch_entry_t         entry_o,
    output logic                         entry_valid_o,
    output fe_pkg::predict_t             predict_o
);
    import fe_pkg::*;

    logic [XLEN-1:0] instr;
    logic [6:0]      opcode;
    logic            is_branch;
    logic            is_jal;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic            taken;

    // --------------------
    // instruction scan
    // --------------------

    assign instr  = fetch_rsp_i.data;
    assign opcode = instr[6:0];

    assign is_branch = (opcode == OPC_BRANCH);
    assign is_jal    = (opcode == OPC_JAL);

    // b-type offset, bit 0 is implicitly zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

    // j-type offset, +-1 MiB range
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // static rule
    // jal always taken, branches taken only when pointing backwards
    // a faulted word carries garbage and is never predicted
    always_comb begin
        taken = 1'b0;
        if (!fetch_rsp_i.err) begin
            if (is_jal) begin
                taken = 1'b1;
            end else if (is_branch) begin
                taken = imm_b[XLEN-1];
            end
        end
    end

    // --------------------
    // entry and prediction
    // --------------------

    // killed answers and answers during a flush never reach the queue
    assign entry_valid_o = fetch_rsp_i.valid & ~drop_i & ~flush_i;

    assign entry_o.pc         = req_addr_i;
    assign entry_o.instr      = instr;
    assign entry_o.pred_taken = taken;
    assign entry_o.fault      = fetch_rsp_i.err;

    // only a word that is actually enqueued may steer fetch
    assign predict_o.taken  = entry_valid_o & taken;
    assign predict_o.target = req_addr_i + (is_jal ? imm_j : imm_b);

    // --------------------
    // checks
    // --------------------

    // pc_gen holds off the request after a taken prediction,
    // so the following cycle never delivers a usable word
    a_taken_kills_next : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        predict_o.taken |=> !entry_valid_o
    ) else $error("entry accepted right after a predicted-taken word");

endmodule

`default_nettype wire

// File: logic/fetch_queue.sv
`default_nettype none

module fetch_queue #(
    // power of two, at least 2
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  wire logic                 clk_i,
    input  wire logic                 rst_ni,
    input  wire logic                 flush_i,
    // write side from predecode
    input  wire fe_pkg::fetch_entry_t entry_i,
    input  wire logic                 entry_valid_i,
    // two or more free slots, one is kept for the word in flight
    output logic                      room_o,
    // read side to the back end
    output fe_pkg::fetch_entry_t      fetch_entry_o,
    output logic                      fetch_valid_o,
    input  wire logic                 fetch_ready_i
);
    import fe_pkg::*;

    localparam int unsigned    PTR_W     = $clog2(QUEUE_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = (PTR_W + 1)'(QUEUE_DEPTH);

    // storage, no reset needed on payload
    fetch_entry_t     mem_q [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    // one bit wider than the pointers to tell full from empty
    logic [PTR_W:0]   count_d;
    logic [PTR_W:0]   count_q;
    logic [PTR_W:0]   free_cnt;
    logic             push;
    logic             pop;

    // --------------------
    // status
    // --------------------

    assign push = entry_valid_i;
    assign pop  = fetch_valid_o & fetch_ready_i;

    assign free_cnt = DEPTH_CNT - count_q;
    assign room_o   = (free_cnt >= (PTR_W + 1)'(2));

    // head of queue, visible the cycle after its write
    assign fetch_valid_o = (count_q != '0);
    assign fetch_entry_o = mem_q[rd_ptr_q];

    always_comb begin
        count_d = count_q;
        if (push && !pop) begin
            count_d = count_q + 1'b1;
        end else if (pop && !push) begin
            count_d = count_q - 1'b1;
        end
    end

    // --------------------
    // pointers
    // --------------------

    // pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // everything queued is on the wrong path
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    // room_o to pc_gen must leave space for every answer still in flight
    a_no_overflow : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        entry_valid_i |-> (count_q != DEPTH_CNT)
    ) else $error("fetch queue written while full");

endmodule

`default_nettype wire

// File: logic/frontend.sv
`default_nettype none

module frontend #(
    parameter int unsigned QUEUE_DEPTH = 4
) (
    input  wire logic                    clk_i,
    input  wire logic                    rst_ni,
    input  wire logic [fe_pkg::XLEN-1:0] boot_addr_i,
    // back-end and csr redirects
    input  wire fe_pkg::resolve_t        resolve_i,
    input  wire fe_pkg::trap_t           trap_i,
    // instruction memory
    output fe_pkg::fetch_req_t           fetch_req_o,
    input  wire fe_pkg::fetch_rsp_t      fetch_rsp_i,
    // decode stage
    output fe_pkg::fetch_entry_t         fetch_entry_o,
    output logic                         fetch_valid_o,
    input  wire logic                    fetch_ready_i
);
    import fe_pkg::*;

    logic [XLEN-1:0] req_addr_q;
    logic            drop;
    logic            flush;
    logic            room;
    fetch_entry_t    entry;
    logic            entry_valid;
    predict_t        predict;

    // --------------------
    // pc generation
    // --------------------
    pc_gen i_pc_gen (
        .clk_i        ( clk_i       ),
        .rst_ni       ( rst_ni      ),
        .boot_addr_i  ( boot_addr_i ),
        .resolve_i    ( resolve_i   ),
        .trap_i       ( trap_i      ),
        .predict_i    ( predict     ),
        .room_i       ( room        ),
        .fetch_req_o  ( fetch_req_o ),
        .req_addr_q_o ( req_addr_q  ),
        .drop_o       ( drop        ),
        .flush_o      ( flush       )
    );

    // --------------------
    // predecode and queue
    // --------------------
    predecode i_predecode (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .fetch_rsp_i   ( fetch_rsp_i ),
        .req_addr_i    ( req_addr_q  ),
        .drop_i        ( drop        ),
        .flush_i       ( flush       ),
        .entry_o       ( entry       ),
        .entry_valid_o ( entry_valid ),
        .predict_o     ( predict     )
    );

    fetch_queue #(
        .QUEUE_DEPTH ( QUEUE_DEPTH )
    ) i_fetch_queue (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .flush_i       ( flush         ),
        .entry_i       ( entry         ),
        .entry_valid_i ( entry_valid   ),
        .room_o        ( room          ),
        .fetch_entry_o ( fetch_entry_o ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_ready_i ( fetch_ready_i )
    );

    // memory side, an answer always pairs with last cycle's request
    a_rsp_has_req : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        fetch_rsp_i.valid |-> $past(fetch_req_o.req)
    ) else $error("memory answer without a request");

endmodule

`default_nettype wire

// File: verif/tb_checks.svh
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// --------------------
// counters
// --------------------

int unsigned check_cnt = 0;
int unsigned err_cnt   = 0;

// failures that are not a value mismatch
task automatic note_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_cnt++;
endtask

// --------------------
// typed compares
// --------------------

// one full queue entry, all four fields at once
task automatic compare_entry(input string name, input fetch_entry_t got,
                             input fetch_entry_t exp);
    check_cnt++;
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got pc=%h instr=%h taken=%b fault=%b",
                 $time, name, got.pc, got.instr, got.pred_taken, got.fault);
        $display("CHECK FAILED at %0t: %s expected pc=%h instr=%h taken=%b fault=%b",
                 $time, name, exp.pc, exp.instr, exp.pred_taken, exp.fault);
        err_cnt++;
    end
endtask

// addresses and single status bits, zero extended
task automatic compare_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        err_cnt++;
    end
endtask

`endif

// File: verif/tb_frontend.sv
`default_nettype none

module tb_frontend;
    timeunit 1ns;
    timeprecision 100ps;
    import fe_pkg::*;

    localparam int          CLK_PERIOD    = 100;
    localparam int          RESET_CYCLES  = 10;
    localparam int          NUM_TESTS     = 5;
    localparam int          COLLECT_LIMIT = 500;
    localparam logic [31:0] SEED          = 32'h61951ca4;
    localparam logic [31:0] BOOT_ADDR     = 32'h0000_1000;
    // words in this range answer with an access error
    localparam logic [31:0] ERR_LO        = 32'h0000_4000;
    localparam logic [31:0] ERR_HI        = 32'h0000_4010;

    logic            clk_i = 1'b0;
    logic            rst_ni;
    logic [XLEN-1:0] boot_addr_i;
    resolve_t        resolve_i;
    trap_t           trap_i;
    fetch_req_t      fetch_req_o;
    fetch_rsp_t      fetch_rsp_i;
    fetch_entry_t    fetch_entry_o;
    logic            fetch_valid_o;
    logic            fetch_ready_i;

    // sparse program, unset words fall back to an address pattern
    logic [31:0]     prog [logic [31:0]];
    // offset and kind of every placed jump or branch
    logic [31:0]     cf_off [logic [31:0]];
    logic            cf_jal [logic [31:0]];
    fetch_req_t      req_seen = '0;
    fetch_entry_t    accepted [$];
    fetch_entry_t    expected [$];

    `include "tb_checks.svh"

    frontend #(
        .QUEUE_DEPTH ( 4 )
    ) dut_i (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .resolve_i     ( resolve_i     ),
        .trap_i        ( trap_i        ),
        .fetch_req_o   ( fetch_req_o   ),
        .fetch_rsp_i   ( fetch_rsp_i   ),
        .fetch_entry_o ( fetch_entry_o ),
        .fetch_valid_o ( fetch_valid_o ),
        .fetch_ready_i ( fetch_ready_i )
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // --------------------
    // program helpers
    // --------------------

    function automatic logic [31:0] word_at(input logic [31:0] addr);
        if (prog.exists(addr)) begin
            return prog[addr];
        end
        // alu op, fields depend on every address bit
        return {addr[24:0] ^ addr[31:7], 7'b0010011};
    endfunction

    function automatic logic in_err_range(input logic [31:0] addr);
        return (addr >= ERR_LO) && (addr < ERR_HI);
    endfunction

    // beq x1, x2, off
    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        return {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    // jal x1, off
    function automatic logic [31:0] enc_jal(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    task automatic place_jal(input logic [31:0] addr, input logic [20:0] off);
        prog[addr]   = enc_jal(off);
        cf_off[addr] = {{11{off[20]}}, off};
        cf_jal[addr] = 1'b1;
    endtask

    task automatic place_branch(input logic [31:0] addr, input logic [12:0] off);
        prog[addr]   = enc_branch(off);
        cf_off[addr] = {{19{off[12]}}, off};
        cf_jal[addr] = 1'b0;
    endtask

    task automatic load_program();
        logic [31:0] r;
        for (logic [31:0] a = BOOT_ADDR; a < BOOT_ADDR + 32'h100; a += 4) begin
            r = $urandom;
            prog[a] = {r[31:7], 7'b0110011};
        end
        place_jal(32'h1080, -21'sd64);
        place_branch(32'h2004, 13'sd12);
        place_jal(32'h200c, 21'sd32);
        place_branch(32'h2030, -13'sd8);
        place_branch(32'h3108, -13'sd8);
        // control flow inside the error range must stay unpredicted
        place_jal(32'h4004, 21'sd256);
        place_branch(32'h4008, -13'sd16);
    endtask

    // walk the program with the static rule from a start address
    task automatic build_expected(input logic [31:0] start, input int n);
        fetch_entry_t e;
        logic [31:0]  pc;
        logic [31:0]  tgt;
        pc = start;
        expected.delete();
        repeat (n) begin
            e.pc         = pc;
            e.instr      = word_at(pc);
            e.fault      = in_err_range(pc);
            e.pred_taken = 1'b0;
            tgt          = pc + 32'd4;
            // jal always, a branch only when its offset points backwards
            if (!e.fault && cf_off.exists(pc) && (cf_jal[pc] || cf_off[pc][31])) begin
                e.pred_taken = 1'b1;
                tgt          = pc + cf_off[pc];
            end
            expected.push_back(e);
            pc = tgt;
        end
    endtask

    // --------------------
    // memory and back end
    // --------------------

    // request is stable by the falling edge
    always @(negedge clk_i) begin
        req_seen = fetch_req_o;
    end

    // answer one cycle after the request
    always @(posedge clk_i) begin
        #1;
        fetch_rsp_i.valid = req_seen.req;
        fetch_rsp_i.data  = word_at(req_seen.addr);
        fetch_rsp_i.err   = req_seen.req && in_err_range(req_seen.addr);
    end

    always @(negedge clk_i) begin
        if (rst_ni === 1'b1 && fetch_valid_o && fetch_ready_i) begin
            accepted.push_back(fetch_entry_o);
        end
    end

    // --------------------
    // stimulus tasks
    // --------------------

    task automatic collect(input int n, input bit random_ready, input string what);
        int cycles;
        cycles = 0;
        while (accepted.size() < n && cycles < COLLECT_LIMIT) begin
            fetch_ready_i = random_ready ? 1'($urandom % 2) : 1'b1;
            @(posedge clk_i);
            #1;
            cycles++;
        end
        if (accepted.size() < n) begin
            note_failure($sformatf("%s: only %0d of %0d entries arrived in time",
                                   what, accepted.size(), n));
        end
    endtask

    task automatic check_stream(input logic [31:0] start, input int n, input string what);
        build_expected(start, n);
        if (accepted.size() > 0) begin
            compare_word({what, " first pc"}, accepted[0].pc, start);
        end
        for (int i = 0; i < n && i < accepted.size(); i++) begin
            compare_entry($sformatf("%s fetch_entry_o[%0d]", what, i), accepted[i], expected[i]);
        end
    endtask

    // one-cycle strobe with ready low, then forget older entries
    task automatic drive_redirect(input bit mis, input bit ex, input bit er,
                                  input logic [31:0] mis_tgt, input logic [31:0] vec,
                                  input logic [31:0] epc);
        @(posedge clk_i);
        #1;
        fetch_ready_i         = 1'b0;
        resolve_i.mispredict  = mis;
        resolve_i.target      = mis_tgt;
        trap_i.ex_valid       = ex;
        trap_i.trap_vector    = vec;
        trap_i.eret           = er;
        trap_i.epc            = epc;
        @(posedge clk_i);
        #1;
        resolve_i = '0;
        trap_i    = '0;
        accepted.delete();
    endtask

    // let the queue fill partly before a redirect
    task automatic stall_backend(input int n);
        fetch_ready_i = 1'b0;
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
        compare_word("fetch_valid_o while stalled", fetch_valid_o, 1);
    endtask

    task automatic report_test(input string name, input int unsigned errs0);
        if (err_cnt == errs0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - errs0);
        end
    endtask

    // --------------------
    // directed tests
    // --------------------

    task automatic test_boot_stream();
        int unsigned errs0;
        errs0 = err_cnt;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        compare_word("fetch_req_o.req in reset", fetch_req_o.req, 0);
        compare_word("fetch_valid_o in reset", fetch_valid_o, 0);
        rst_ni = 1'b1;
        accepted.delete();
        collect(12, 1'b0, "boot");
        check_stream(BOOT_ADDR, 12, "boot");
        report_test("boot_stream", errs0);
    endtask

    task automatic test_static_prediction();
        int unsigned errs0;
        errs0 = err_cnt;
        drive_redirect(1'b1, 1'b0, 1'b0, 32'h2000, 32'h5000, 32'h5100);
        collect(12, 1'b0, "predict");
        check_stream(32'h2000, 12, "predict");
        report_test("static_prediction", errs0);
    endtask

    task automatic test_backpressure();
        int unsigned errs0;
        errs0 = err_cnt;
        drive_redirect(1'b0, 1'b1, 1'b0, 32'h5000, BOOT_ADDR, 32'h5100);
        collect(48, 1'b1, "backpressure");
        check_stream(BOOT_ADDR, 48, "backpressure");
        report_test("backpressure", errs0);
    endtask

    task automatic test_redirects();
        int unsigned errs0;
        errs0 = err_cnt;
        stall_backend(4);
        drive_redirect(1'b1, 1'b0, 1'b0, 32'h3000, 32'h5000, 32'h5100);
        collect(6, 1'b0, "mispredict");
        check_stream(32'h3000, 6, "mispredict");
        stall_backend(4);
        drive_redirect(1'b0, 1'b0, 1'b1, 32'h5000, 32'h5200, 32'h3100);
        collect(8, 1'b0, "eret");
        check_stream(32'h3100, 8, "eret");
        stall_backend(4);
        drive_redirect(1'b0, 1'b1, 1'b0, 32'h5000, 32'h3200, 32'h5100);
        collect(6, 1'b0, "exception");
        check_stream(32'h3200, 6, "exception");
        // exception has priority over a simultaneous eret
        stall_backend(4);
        drive_redirect(1'b0, 1'b1, 1'b1, 32'h5000, 32'h3300, 32'h3400);
        collect(6, 1'b0, "exception and eret");
        check_stream(32'h3300, 6, "exception and eret");
        report_test("redirects", errs0);
    endtask

    task automatic test_access_fault();
        int unsigned errs0;
        errs0 = err_cnt;
        drive_redirect(1'b1, 1'b0, 1'b0, 32'h3ff8, 32'h5000, 32'h5100);
        collect(8, 1'b0, "fault");
        check_stream(32'h3ff8, 8, "fault");
        report_test("access_fault", errs0);
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        rst_ni        = 1'b0;
        boot_addr_i   = BOOT_ADDR;
        resolve_i     = '0;
        trap_i        = '0;
        fetch_rsp_i   = '0;
        fetch_ready_i = 1'b1;
        void'($urandom(SEED));
        load_program();
        test_boot_stream();
        test_static_prediction();
        test_backpressure();
        test_redirects();
        test_access_fault();
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // watchdog, 2000 cycles per test
    initial begin
        #(NUM_TESTS * 2000 * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+verif
logic/fe_pkg.sv
logic/pc_gen.sv
logic/predecode.sv
logic/fetch_queue.sv
logic/frontend.sv
verif/tb_frontend.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then scan the log for the failure line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_frontend \
    -o tb_frontend > build.log 2>&1 \
    && ./obj_dir/tb_frontend > sim.log 2>&1 \
    || echo "sim failed" >> sim.log
cat sim.log
if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
